// ==== source/dataPathPkg.sv ====
// Shared widths, instruction field positions and opcode types for the datapath blocks
package dataPathPkg;

   // Data and bus width
   localparam int wordWidth = 32;

   // General register file
   localparam int regCount = 16;
   localparam int regSelWidth = 4;

   // Word memory, addressed by the low bits of MAR
   localparam int memDepth = 512;
   localparam int memAddrWidth = 9;

   // Instruction register fields
   localparam int raLsb = 23;
   localparam int rbLsb = 19;
   localparam int rcLsb = 15;
   localparam int immWidth = 19;

   // Branch condition sits in the low two bits of the Rb field
   localparam int condLsb = 19;

   // ALU operations, opAdd keeps the encoding used by existing control sequences
   typedef enum logic [4:0] {
      opShr = 5'd0,
      opShra = 5'd1,
      opShl = 5'd2,
      opRor = 5'd3,
      opAdd = 5'd4,
      opSub = 5'd5,
      opAnd = 5'd6,
      opOr = 5'd7,
      opRol = 5'd8,
      opMul = 5'd9,
      opNeg = 5'd10,
      opNot = 5'd11
   } aluOp;

   // Conditional branch tests applied to the bus value
   typedef enum logic [1:0] {
      condZero = 2'd0,
      condNonZero = 2'd1,
      condPositive = 2'd2,
      condNegative = 2'd3
   } branchCond;

endpackage

// ==== source/programRegisters.sv ====
// Program counter, instruction register, immediate sign extension and branch flag
`timescale 1ns/1ps

module programRegisters (
   input  logic Clock,
   input  logic rstN,
   input  logic [dataPathPkg::wordWidth-1:0] busValue,
   input  logic PCin,
   input  logic IncPC,
   input  logic IRin,
   input  logic CONFFin,
   output logic [dataPathPkg::wordWidth-1:0] pcValue,
   output logic [dataPathPkg::wordWidth-1:0] irValue,
   output logic [dataPathPkg::wordWidth-1:0] immValue,
   output logic branch
);

   dataPathPkg::branchCond cond;
   logic condMet;

   // C field sign extended to a full word
   assign immValue = {{(dataPathPkg::wordWidth - dataPathPkg::immWidth)
                        {irValue[dataPathPkg::immWidth-1]}},
                      irValue[dataPathPkg::immWidth-1:0]};

   assign cond = dataPathPkg::branchCond'(irValue[dataPathPkg::condLsb+1:dataPathPkg::condLsb]);

   // Condition tested against whatever is on the bus now
   always_comb begin
      condMet = 1'b0;
      case (cond)
         dataPathPkg::condZero: begin
            condMet = (busValue == '0);
         end
         dataPathPkg::condNonZero: begin
            condMet = (busValue != '0);
         end
         dataPathPkg::condPositive: begin
            condMet = !busValue[dataPathPkg::wordWidth-1] && (busValue != '0);
         end
         dataPathPkg::condNegative: begin
            condMet = busValue[dataPathPkg::wordWidth-1];
         end
         default: begin
            condMet = 1'b0;
         end
      endcase
   end

   // PCin takes priority over the increment
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         pcValue <= '0;
      end else if (PCin) begin
         pcValue <= busValue;
      end else if (IncPC) begin
         pcValue <= pcValue + 1;
      end
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         irValue <= '0;
         branch <= 1'b0;
      end else begin
         if (IRin) begin
            irValue <= busValue;
         end
         if (CONFFin) begin
            branch <= condMet;
         end
      end
   end

endmodule

// ==== source/memoryUnit.sv ====
// MAR, MDR and the word memory, with a one-cycle completion pulse per access
`timescale 1ns/1ps

module memoryUnit (
   input  logic Clock,
   input  logic rstN,
   input  logic [dataPathPkg::wordWidth-1:0] busValue,
   input  logic MARin,
   input  logic MDRin,
   input  logic Read,
   input  logic Write,
   output logic [dataPathPkg::wordWidth-1:0] marValue,
   output logic [dataPathPkg::wordWidth-1:0] mdrValue,
   output logic memFinished
);

   logic [dataPathPkg::wordWidth-1:0] memArray [dataPathPkg::memDepth];
   logic [dataPathPkg::memAddrWidth-1:0] memAddr;
   logic accessActive;
   logic accessPrev;
   logic accessStart;

   assign memAddr = marValue[dataPathPkg::memAddrWidth-1:0];
   assign accessActive = Read || Write;

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         marValue <= '0;
         mdrValue <= '0;
      end else begin
         if (MARin) begin
            marValue <= busValue;
         end
         // Read selects the memory word instead of the bus
         if (MDRin) begin
            mdrValue <= Read ? memArray[memAddr] : busValue;
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (Write) begin
         memArray[memAddr] <= mdrValue;
      end
   end

   // First edge of an access arms the pulse, the next edge raises it
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         accessPrev <= 1'b0;
         accessStart <= 1'b0;
         memFinished <= 1'b0;
      end else begin
         accessPrev <= accessActive;
         accessStart <= accessActive && !accessPrev;
         memFinished <= accessStart;
      end
   end

endmodule

// ==== source/registerFile.sv ====
// Sixteen general registers, selected directly or through the instruction fields
`timescale 1ns/1ps

module registerFile (
   input  logic Clock,
   input  logic rstN,
   input  logic [dataPathPkg::wordWidth-1:0] busValue,
   input  logic [dataPathPkg::wordWidth-1:0] irValue,
   input  logic [dataPathPkg::regSelWidth-1:0] RFSelect,
   input  logic Gra,
   input  logic Grb,
   input  logic Grc,
   input  logic RFin,
   input  logic Rin,
   input  logic BAout,
   output logic [dataPathPkg::wordWidth-1:0] readValue
);

   logic [dataPathPkg::wordWidth-1:0] regs [dataPathPkg::regCount];
   logic [dataPathPkg::regSelWidth-1:0] regSel;

   // Instruction fields override the direct select
   always_comb begin
      if (Gra) begin
         regSel = irValue[dataPathPkg::raLsb +: dataPathPkg::regSelWidth];
      end else if (Grb) begin
         regSel = irValue[dataPathPkg::rbLsb +: dataPathPkg::regSelWidth];
      end else if (Grc) begin
         regSel = irValue[dataPathPkg::rcLsb +: dataPathPkg::regSelWidth];
      end else begin
         regSel = RFSelect;
      end
   end

   // R0 acts as a zero base for address arithmetic
   assign readValue = (BAout && (regSel == '0)) ? '0 : regs[regSel];

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         for (int i = 0; i < dataPathPkg::regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (RFin || Rin) begin
         regs[regSel] <= busValue;
      end
   end

endmodule

// ==== source/aluUnit.sv ====
// ALU with operand register RY, 64-bit result register RZ and the HI/LO pair
`timescale 1ns/1ps

module aluUnit (
   input  logic Clock,
   input  logic rstN,
   input  logic [dataPathPkg::wordWidth-1:0] busValue,
   input  dataPathPkg::aluOp opSelect,
   input  logic start,
   input  logic RYin,
   input  logic RZin,
   input  logic RHIin,
   input  logic RLOin,
   output logic [dataPathPkg::wordWidth-1:0] ryValue,
   output logic [dataPathPkg::wordWidth-1:0] zLowValue,
   output logic [dataPathPkg::wordWidth-1:0] zHighValue,
   output logic [dataPathPkg::wordWidth-1:0] hiValue,
   output logic [dataPathPkg::wordWidth-1:0] loValue,
   output logic finished
);

   logic signed [2*dataPathPkg::wordWidth-1:0] product;
   logic [2*dataPathPkg::wordWidth-1:0] rorWide;
   logic [2*dataPathPkg::wordWidth-1:0] rolWide;
   logic [2*dataPathPkg::wordWidth-1:0] result;
   logic [4:0] shiftAmount;
   logic startPrev;
   logic opPending;

   assign shiftAmount = busValue[4:0];
   assign product = (2*dataPathPkg::wordWidth)'($signed(ryValue))
                    * (2*dataPathPkg::wordWidth)'($signed(busValue));

   // Rotates taken from a doubled copy of RY
   assign rorWide = {ryValue, ryValue} >> shiftAmount;
   assign rolWide = {ryValue, ryValue} << shiftAmount;

   always_comb begin
      result = '0;
      case (opSelect)
         dataPathPkg::opAdd:  result[dataPathPkg::wordWidth-1:0] = ryValue + busValue;
         dataPathPkg::opSub:  result[dataPathPkg::wordWidth-1:0] = ryValue - busValue;
         dataPathPkg::opAnd:  result[dataPathPkg::wordWidth-1:0] = ryValue & busValue;
         dataPathPkg::opOr:   result[dataPathPkg::wordWidth-1:0] = ryValue | busValue;
         dataPathPkg::opShr:  result[dataPathPkg::wordWidth-1:0] = ryValue >> shiftAmount;
         dataPathPkg::opShra: result[dataPathPkg::wordWidth-1:0] =
                                 $signed(ryValue) >>> shiftAmount;
         dataPathPkg::opShl:  result[dataPathPkg::wordWidth-1:0] = ryValue << shiftAmount;
         dataPathPkg::opRor:  result[dataPathPkg::wordWidth-1:0] =
                                 rorWide[dataPathPkg::wordWidth-1:0];
         dataPathPkg::opRol:  result[dataPathPkg::wordWidth-1:0] =
                                 rolWide[2*dataPathPkg::wordWidth-1:dataPathPkg::wordWidth];
         dataPathPkg::opMul:  result = product;
         dataPathPkg::opNeg:  result[dataPathPkg::wordWidth-1:0] = -busValue;
         dataPathPkg::opNot:  result[dataPathPkg::wordWidth-1:0] = ~busValue;
         default:             result = '0;
      endcase
   end

   // Rising start launches one operation, completed on the following edge
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         startPrev <= 1'b0;
         opPending <= 1'b0;
         finished <= 1'b0;
      end else begin
         startPrev <= start;
         opPending <= start && !startPrev;
         finished <= opPending;
      end
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         ryValue <= '0;
         zLowValue <= '0;
         zHighValue <= '0;
         hiValue <= '0;
         loValue <= '0;
      end else begin
         if (RYin) begin
            ryValue <= busValue;
         end
         if (opPending && RZin) begin
            zLowValue <= result[dataPathPkg::wordWidth-1:0];
            zHighValue <= result[2*dataPathPkg::wordWidth-1:dataPathPkg::wordWidth];
         end
         if (RHIin) begin
            hiValue <= busValue;
         end
         if (RLOin) begin
            loValue <= busValue;
         end
      end
   end

endmodule

// ==== source/busMux.sv ====
// Priority selector that places one source onto the shared bus, zero when idle
`timescale 1ns/1ps

module busMux (
   input  logic [dataPathPkg::wordWidth-1:0] readValue,
   input  logic RFout,
   input  logic Rout,
   input  logic [dataPathPkg::wordWidth-1:0] pcValue,
   input  logic PCout,
   input  logic [dataPathPkg::wordWidth-1:0] irValue,
   input  logic IRout,
   input  logic [dataPathPkg::wordWidth-1:0] ryValue,
   input  logic RYout,
   input  logic [dataPathPkg::wordWidth-1:0] zLowValue,
   input  logic RZLOout,
   input  logic [dataPathPkg::wordWidth-1:0] zHighValue,
   input  logic RZHIout,
   input  logic [dataPathPkg::wordWidth-1:0] marValue,
   input  logic MARout,
   input  logic [dataPathPkg::wordWidth-1:0] hiValue,
   input  logic RHIout,
   input  logic [dataPathPkg::wordWidth-1:0] loValue,
   input  logic RLOout,
   input  logic [dataPathPkg::wordWidth-1:0] immValue,
   input  logic Immout,
   input  logic [dataPathPkg::wordWidth-1:0] mdrValue,
   input  logic MDRout,
   input  logic [dataPathPkg::wordWidth-1:0] extData,
   input  logic extIn,
   output logic [dataPathPkg::wordWidth-1:0] busValue
);

   // External injection first, then the datapath sources in fixed order
   always_comb begin
      if (extIn)                 busValue = extData;
      else if (RFout || Rout)    busValue = readValue;
      else if (PCout)            busValue = pcValue;
      else if (IRout)            busValue = irValue;
      else if (RYout)            busValue = ryValue;
      else if (RZLOout)          busValue = zLowValue;
      else if (RZHIout)          busValue = zHighValue;
      else if (MARout)           busValue = marValue;
      else if (RHIout)           busValue = hiValue;
      else if (RLOout)           busValue = loValue;
      else if (Immout)           busValue = immValue;
      else if (MDRout)           busValue = mdrValue;
      else                       busValue = '0;
   end

endmodule

// ==== source/dataPath.sv ====
// Single-bus datapath top, wiring every register block around the shared bus
`timescale 1ns/1ps

module dataPath (
   input  logic Clock,
   input  logic rstN,
   // Bus source strobes
   input  logic RFout,
   input  logic Rout,
   input  logic PCout,
   input  logic IRout,
   input  logic RYout,
   input  logic RZLOout,
   input  logic RZHIout,
   input  logic MARout,
   input  logic RHIout,
   input  logic RLOout,
   input  logic Immout,
   input  logic MDRout,
   // Register load strobes
   input  logic RFin,
   input  logic Rin,
   input  logic PCin,
   input  logic IncPC,
   input  logic IRin,
   input  logic RYin,
   input  logic RZin,
   input  logic RHIin,
   input  logic RLOin,
   input  logic MARin,
   input  logic MDRin,
   input  logic CONFFin,
   input  logic Read,
   input  logic Write,
   input  logic Gra,
   input  logic Grb,
   input  logic Grc,
   input  logic BAout,
   input  logic start,
   input  logic [dataPathPkg::regSelWidth-1:0] RFSelect,
   input  dataPathPkg::aluOp opSelect,
   input  logic extIn,
   input  logic [dataPathPkg::wordWidth-1:0] extData,
   output logic [dataPathPkg::wordWidth-1:0] busValue,
   output logic finished,
   output logic memFinished,
   output logic branch
);

   logic [dataPathPkg::wordWidth-1:0] pcValue;
   logic [dataPathPkg::wordWidth-1:0] irValue;
   logic [dataPathPkg::wordWidth-1:0] immValue;
   logic [dataPathPkg::wordWidth-1:0] marValue;
   logic [dataPathPkg::wordWidth-1:0] mdrValue;
   logic [dataPathPkg::wordWidth-1:0] readValue;
   logic [dataPathPkg::wordWidth-1:0] ryValue;
   logic [dataPathPkg::wordWidth-1:0] zLowValue;
   logic [dataPathPkg::wordWidth-1:0] zHighValue;
   logic [dataPathPkg::wordWidth-1:0] hiValue;
   logic [dataPathPkg::wordWidth-1:0] loValue;

   programRegisters programRegs (
      .Clock(Clock), .rstN(rstN), .busValue(busValue),
      .PCin(PCin), .IncPC(IncPC), .IRin(IRin), .CONFFin(CONFFin),
      .pcValue(pcValue), .irValue(irValue), .immValue(immValue), .branch(branch)
   );

   memoryUnit memory (
      .Clock(Clock), .rstN(rstN), .busValue(busValue),
      .MARin(MARin), .MDRin(MDRin), .Read(Read), .Write(Write),
      .marValue(marValue), .mdrValue(mdrValue), .memFinished(memFinished)
   );

   registerFile regFile (
      .Clock(Clock), .rstN(rstN), .busValue(busValue), .irValue(irValue),
      .RFSelect(RFSelect), .Gra(Gra), .Grb(Grb), .Grc(Grc),
      .RFin(RFin), .Rin(Rin), .BAout(BAout), .readValue(readValue)
   );

   aluUnit alu (
      .Clock(Clock), .rstN(rstN), .busValue(busValue), .opSelect(opSelect),
      .start(start), .RYin(RYin), .RZin(RZin), .RHIin(RHIin), .RLOin(RLOin),
      .ryValue(ryValue), .zLowValue(zLowValue), .zHighValue(zHighValue),
      .hiValue(hiValue), .loValue(loValue), .finished(finished)
   );

   busMux bus (
      .readValue(readValue), .RFout(RFout), .Rout(Rout),
      .pcValue(pcValue), .PCout(PCout), .irValue(irValue), .IRout(IRout),
      .ryValue(ryValue), .RYout(RYout),
      .zLowValue(zLowValue), .RZLOout(RZLOout), .zHighValue(zHighValue), .RZHIout(RZHIout),
      .marValue(marValue), .MARout(MARout),
      .hiValue(hiValue), .RHIout(RHIout), .loValue(loValue), .RLOout(RLOout),
      .immValue(immValue), .Immout(Immout), .mdrValue(mdrValue), .MDRout(MDRout),
      .extData(extData), .extIn(extIn), .busValue(busValue)
   );

endmodule

// ==== test/dataPathTb.sv ====
// Directed testbench for the single-bus datapath, drives control strobes and checks the bus
`timescale 1ns/1ps

module dataPathTb;

   logic Clock;
   logic rstN;
   logic RFout, Rout, PCout, IRout, RYout, RZLOout, RZHIout;
   logic MARout, RHIout, RLOout, Immout, MDRout, BAout;
   logic RFin, Rin, PCin, IncPC, IRin, RYin, RZin, RHIin, RLOin;
   logic MARin, MDRin, CONFFin, Read, Write, Gra, Grb, Grc, start, extIn;
   logic [dataPathPkg::regSelWidth-1:0] RFSelect;
   dataPathPkg::aluOp opSelect;
   logic [dataPathPkg::wordWidth-1:0] extData;
   logic [dataPathPkg::wordWidth-1:0] busValue;
   logic finished, memFinished, branch;
   integer seed;

   // Expected branch flag per condition for bus values zero, positive, negative
   localparam logic [2:0] branchTable [4] = '{3'b100, 3'b011, 3'b010, 3'b001};

   dataPath UUT (.*);

   always #20 Clock = ~Clock;

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("Test failures found");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   // Waits for the next edge, then drops every strobe so the caller sets only its own
   task automatic nextCycle();
      @(posedge Clock);
      {RFout, Rout, PCout, IRout, RYout, RZLOout, RZHIout, MARout, RHIout, RLOout} <= '0;
      {Immout, MDRout, BAout, RFin, Rin, PCin, IncPC, IRin, RYin, RZin, RHIin} <= '0;
      {RLOin, MARin, MDRin, CONFFin, Read, Write, Gra, Grb, Grc, start, extIn} <= '0;
      RFSelect <= '0;
   endtask

   task automatic driveExt(input logic [31:0] value);
      nextCycle();
      extIn <= 1'b1;
      extData <= value;
   endtask

   task automatic expectBus(input string name, input logic [31:0] expected);
      @(negedge Clock);
      checkValue(name, busValue, expected);
   endtask

   // Strobes stay as the caller left them while waiting
   task automatic waitDone(input bit useMemory, input string what);
      int cycles;
      cycles = 0;
      do begin
         @(negedge Clock);
         cycles++;
      end while (!(useMemory ? memFinished : finished) && cycles < 10);
      if (!(useMemory ? memFinished : finished)) begin
         $display("Timed out waiting for the %s to complete", what);
         $display("Test failures found");
         $fatal(1, "Completion pulse never arrived");
      end
   endtask

   // Access strobe is still held here, so a second pulse would show up now
   task automatic checkSinglePulse();
      @(negedge Clock);
      checkValue("memFinished one cycle later", 32'(memFinished), 32'd0);
   endtask

   task automatic memStore(input logic [31:0] addr, input logic [31:0] word);
      driveExt(addr);
      MARin <= 1'b1;
      driveExt(word);
      MDRin <= 1'b1;
      nextCycle();
      Write <= 1'b1;
      waitDone(1'b1, "memory write");
      checkSinglePulse();
   endtask

   // MDR loads from memory at the current MAR
   task automatic readMemory();
      nextCycle();
      Read <= 1'b1;
      MDRin <= 1'b1;
      waitDone(1'b1, "memory read");
      checkSinglePulse();
   endtask

   function automatic logic [63:0] aluModel(input dataPathPkg::aluOp op,
                                            input logic [31:0] y, input logic [31:0] b);
      logic [5:0] s;
      logic [63:0] signFilled;
      s = {1'b0, b[4:0]};
      signFilled = {{32{y[31]}}, y} >> s;
      case (op)
         dataPathPkg::opAdd: return {32'd0, y + b};
         dataPathPkg::opSub: return {32'd0, y - b};
         dataPathPkg::opAnd: return {32'd0, y & b};
         dataPathPkg::opOr: return {32'd0, y | b};
         dataPathPkg::opShr: return {32'd0, y >> s};
         dataPathPkg::opShra: return {32'd0, signFilled[31:0]};
         dataPathPkg::opShl: return {32'd0, y << s};
         dataPathPkg::opRor: return {32'd0, (y >> s) | (y << (6'd32 - s))};
         dataPathPkg::opRol: return {32'd0, (y << s) | (y >> (6'd32 - s))};
         dataPathPkg::opMul: return longint'($signed(y)) * longint'($signed(b));
         dataPathPkg::opNeg: return {32'd0, 32'd0 - b};
         dataPathPkg::opNot: return {32'd0, ~b};
         default: return 64'd0;
      endcase
   endfunction

   task automatic checkResetAndLoads();
      logic [31:0] pc, hi, lo, mar;
      nextCycle();
      @(negedge Clock);
      checkValue("idle busValue", busValue, 32'd0);
      checkValue("finished/memFinished/branch", {29'd0, finished, memFinished, branch}, 32'd0);
      pc = $random(seed);
      hi = $random(seed);
      lo = $random(seed);
      mar = $random(seed);
      driveExt(pc);
      PCin <= 1'b1;
      driveExt(hi);
      RHIin <= 1'b1;
      driveExt(lo);
      RLOin <= 1'b1;
      driveExt(mar);
      MARin <= 1'b1;
      nextCycle();
      PCout <= 1'b1;
      expectBus("PC", pc);
      nextCycle();
      RHIout <= 1'b1;
      expectBus("HI", hi);
      nextCycle();
      RLOout <= 1'b1;
      expectBus("LO", lo);
      nextCycle();
      MARout <= 1'b1;
      expectBus("MAR", mar);
   endtask

   task automatic checkRegisters();
      logic [31:0] values [16];
      for (int r = 0; r < 16; r++) begin
         values[r] = $random(seed);
         driveExt(values[r]);
         RFSelect <= r[3:0];
         RFin <= 1'b1;
      end
      for (int r = 0; r < 16; r++) begin
         nextCycle();
         RFSelect <= r[3:0];
         RFout <= 1'b1;
         expectBus($sformatf("R%0d", r), values[r]);
      end
      nextCycle();
      BAout <= 1'b1;
      RFout <= 1'b1;
      expectBus("R0 under BAout", 32'd0);
   endtask

   task automatic checkMemory();
      logic [31:0] words [4];
      for (int i = 0; i < 4; i++) begin
         words[i] = $random(seed);
         memStore(32'(i * 37 + 5), words[i]);
      end
      for (int i = 3; i >= 0; i--) begin
         driveExt(32'(i * 37 + 5));
         MARin <= 1'b1;
         readMemory();
         nextCycle();
         MDRout <= 1'b1;
         expectBus("MDR after read", words[i]);
      end
   endtask

   // RY loads on the start edge, the second operand is on the bus one edge later
   task automatic checkAlu();
      logic [31:0] y, b;
      logic [63:0] expected;
      for (int round = 0; round < 2; round++) begin
         for (int k = 0; k < 12; k++) begin
            y = $random(seed);
            b = $random(seed);
            expected = aluModel(dataPathPkg::aluOp'(k[4:0]), y, b);
            driveExt(y);
            RYin <= 1'b1;
            start <= 1'b1;
            opSelect <= dataPathPkg::aluOp'(k[4:0]);
            driveExt(b);
            RZin <= 1'b1;
            waitDone(1'b0, "ALU operation");
            nextCycle();
            RZLOout <= 1'b1;
            expectBus($sformatf("RZ low for op %0d", k), expected[31:0]);
            nextCycle();
            RZHIout <= 1'b1;
            expectBus($sformatf("RZ high for op %0d", k), expected[63:32]);
         end
      end
   endtask

   // ld R1, C(R2) with C = -3, so the data word sits just below the base
   task automatic checkLoadInstruction();
      logic [31:0] pcStart, base, dataWord;
      pcStart = 32'h0000_0010;
      base = 32'h0000_0040;
      dataWord = $random(seed);
      memStore(pcStart, {5'd0, 4'd1, 4'd2, 19'h7fffd});
      memStore(base - 32'd3, dataWord);
      driveExt(base);
      RFSelect <= 4'd2;
      RFin <= 1'b1;
      driveExt(pcStart);
      PCin <= 1'b1;
      // Instruction fetch
      nextCycle();
      PCout <= 1'b1;
      MARin <= 1'b1;
      IncPC <= 1'b1;
      readMemory();
      nextCycle();
      MDRout <= 1'b1;
      IRin <= 1'b1;
      // Effective address
      nextCycle();
      Grb <= 1'b1;
      BAout <= 1'b1;
      Rout <= 1'b1;
      RYin <= 1'b1;
      start <= 1'b1;
      opSelect <= dataPathPkg::opAdd;
      nextCycle();
      Immout <= 1'b1;
      RZin <= 1'b1;
      waitDone(1'b0, "address add");
      nextCycle();
      RZLOout <= 1'b1;
      MARin <= 1'b1;
      readMemory();
      nextCycle();
      MDRout <= 1'b1;
      Gra <= 1'b1;
      Rin <= 1'b1;
      nextCycle();
      RFSelect <= 4'd1;
      RFout <= 1'b1;
      expectBus("R1 after load", dataWord);
      nextCycle();
      PCout <= 1'b1;
      expectBus("PC after fetch", pcStart + 32'd1);
   endtask

   task automatic checkBranches();
      logic [31:0] samples [3];
      for (int c = 0; c < 4; c++) begin
         samples[0] = 32'd0;
         samples[1] = ($random(seed) & 32'h7fff_ffff) | 32'd1;
         samples[2] = $random(seed) | 32'h8000_0000;
         driveExt(32'(c) << dataPathPkg::condLsb);
         IRin <= 1'b1;
         for (int s = 0; s < 3; s++) begin
            driveExt(samples[s]);
            CONFFin <= 1'b1;
            nextCycle();
            @(negedge Clock);
            checkValue($sformatf("branch for cond %0d sample %0d", c, s), 32'(branch),
                       32'(branchTable[c][2 - s]));
         end
      end
   endtask

   initial begin
      seed = 32'hbd94;
      Clock = 1'b0;
      rstN = 1'b0;
      {RFout, Rout, PCout, IRout, RYout, RZLOout, RZHIout, MARout, RHIout, RLOout} = '0;
      {Immout, MDRout, BAout, RFin, Rin, PCin, IncPC, IRin, RYin, RZin, RHIin} = '0;
      {RLOin, MARin, MDRin, CONFFin, Read, Write, Gra, Grb, Grc, start, extIn} = '0;
      RFSelect = '0;
      opSelect = dataPathPkg::opAdd;
      extData = '0;
      repeat (10) @(posedge Clock);
      rstN <= 1'b1;
      checkResetAndLoads();
      checkRegisters();
      checkMemory();
      checkAlu();
      checkLoadInstruction();
      checkBranches();
      $display("All tests passed!");
      $finish;
   end

endmodule

// ==== verilog.f ====
source/dataPathPkg.sv
source/programRegisters.sv
source/memoryUnit.sv
source/registerFile.sv
source/aluUnit.sv
source/busMux.sv
source/dataPath.sv
test/dataPathTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module dataPathTb -f verilog.f -o dataPathSim \
   && ./obj_dir/dataPathSim \
   || exit 1
